// File: rtl/rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// Data path width of the core
`define RV_XLEN 32

// Destination register address width
`define RV_REG_AW 5

`endif

// File: rtl/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    typedef struct packed {
        logic arith_sub;
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inv;       // Inverts the selected compare
        logic bits_xor;
        logic bits_or;
        logic bits_and;
        logic shift_right;
        logic shift_arith;
    } alu_ctrl_t;

    typedef struct packed {
        logic arith;
        logic cmp;
        logic bits;
        logic shift;
    } alu_res_t;

    typedef enum logic [1:0] {
        RES_ALU     = 2'd0,
        RES_MEM     = 2'd1,
        RES_PC_NEXT = 2'd2
    } res_src_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        alu_res_t              res;
        alu_ctrl_t             ctrl;
        logic                  store;
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic                  jal_jalr;
        logic                  branch;
        logic                  branch_pred;  // Set when fetch already took this path
        logic [`RV_XLEN-1:0]   pc_next;
        logic [`RV_XLEN-1:0]   pc_target_base;
        logic [`RV_XLEN-1:0]   pc_target_offset;
        res_src_t              res_src;
        logic [2:0]            funct3;
        logic [`RV_XLEN-1:0]   reg_data2;
        logic                  csr_read;
        logic [`RV_XLEN-1:0]   csr_data;
        logic                  to_trap;
    } exec_op_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_XLEN-1:0]   add;
        logic                  pc_select;
        logic [`RV_XLEN-1:0]   pc_target;
        logic                  store;
        logic [`RV_XLEN-1:0]   wdata;
        logic [`RV_XLEN/8-1:0] wsel;
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   pc_next;
        res_src_t              res_src;
        logic [2:0]            funct3;
        logic                  to_trap;
    } exec_res_t;

    // Turns an operation into a bubble while its operand fields keep their value
    function automatic exec_op_t clear_ctrl(exec_op_t op);
        exec_op_t k;
        k = op;
        k.rd          = '0;
        k.store       = 1'b0;
        k.reg_write   = 1'b0;
        k.res_src     = RES_ALU;
        k.to_trap     = 1'b0;
        k.branch_pred = 1'b0;
        k.jal_jalr    = 1'b0;
        k.branch      = 1'b0;
        return k;
    endfunction

endpackage

`default_nettype wire

// File: rtl/rv_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_stage_if
#(
    parameter type payload_t = rv_exec_pkg::exec_op_t
)
();

    logic     valid;
    logic     ready;
    payload_t payload;   // Held steady while valid is high

    modport src
    (
        output valid,
        output payload,
        input  ready
    );

    modport dst
    (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// File: rtl/rv_issue_port.sv
`timescale 1ns/1ps
`default_nettype none

module rv_issue_port
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,
    input  logic                  i_req,
    input  rv_exec_pkg::exec_op_t i_op,
    output logic                  o_ack,
    rv_stage_if.src               bus
);

    logic                  hold_valid;
    rv_exec_pkg::exec_op_t hold_op;
    logic                  capture;

    assign capture = i_req && !o_ack && !hold_valid;   // New request and room to take it

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_ack <= 1'b0;
        end
        else if (capture)
        begin
            o_ack <= 1'b1;
        end
        else if (!i_req)
        begin
            o_ack <= 1'b0;   // Host released the request
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            hold_valid <= 1'b0;
        end
        else if (capture)
        begin
            hold_valid <= 1'b1;
        end
        else if (bus.ready)
        begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            hold_op <= rv_exec_pkg::clear_ctrl(hold_op);
        end
        else if (capture)
        begin
            hold_op <= i_op;
        end
    end

    assign bus.valid   = hold_valid;
    assign bus.payload = hold_op;

    // A new request only starts once the ack of the previous cycle has dropped
    a_req_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_req) |-> !o_ack);

endmodule

`default_nettype wire

// File: rtl/rv_alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_alu_exec
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_flush,
    rv_stage_if.dst in_bus,
    rv_stage_if.src out_bus
);

    localparam int MSB   = `RV_XLEN - 1;
    localparam int SHW   = $clog2(`RV_XLEN);
    localparam int LANES = `RV_XLEN / 8;

    rv_exec_pkg::exec_op_t  ex_op;
    rv_exec_pkg::exec_res_t ex_res;
    logic                   ex_valid;
    logic                   op_b_sel;
    logic [MSB:0]           op_b;
    logic [`RV_XLEN:0]      sum;
    logic                   overflow;
    logic                   eq;
    logic                   lts;
    logic                   ltu;
    logic                   cmp_result;
    logic [SHW-1:0]         shamt;
    logic [MSB:0]           bits_result;
    logic [MSB:0]           shl;
    logic [MSB:0]           srl;
    logic [MSB:0]           sra;
    logic [MSB:0]           shift_result;
    logic [MSB:0]           alu_result;

    assign in_bus.ready = !ex_valid || out_bus.ready;   // Empty or handing over this cycle

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            ex_valid <= 1'b0;
        end
        else if (in_bus.valid && in_bus.ready)
        begin
            ex_valid <= 1'b1;
        end
        else if (out_bus.ready)
        begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            ex_op <= rv_exec_pkg::clear_ctrl(ex_op);
        end
        else if (in_bus.valid && in_bus.ready)
        begin
            ex_op <= in_bus.payload;
        end
    end

    // One adder for add, sub and all compares
    assign op_b_sel = ex_op.ctrl.arith_sub || ex_op.res.cmp;
    assign op_b     = op_b_sel ? ~ex_op.op2 : ex_op.op2;
    assign sum      = {1'b0, ex_op.op1} + {1'b0, op_b} + {{`RV_XLEN{1'b0}}, op_b_sel};
    assign overflow = (ex_op.op1[MSB] ^ ex_op.op2[MSB]) & (ex_op.op1[MSB] ^ sum[MSB]);

    assign eq  = ex_op.ctrl.cmp_inv ^ (ex_op.op1 == ex_op.op2);
    assign lts = ex_op.ctrl.cmp_inv ^ (sum[MSB] ^ overflow);
    assign ltu = ex_op.ctrl.cmp_inv ^ !sum[`RV_XLEN];   // No carry out means borrow

    always_comb
    begin
        case (1'b1)
            ex_op.ctrl.cmp_lts: cmp_result = lts;
            ex_op.ctrl.cmp_ltu: cmp_result = ltu;
            default:            cmp_result = eq;
        endcase
    end

    always_comb
    begin
        case (1'b1)
            ex_op.ctrl.bits_xor: bits_result = ex_op.op1 ^ ex_op.op2;
            ex_op.ctrl.bits_or:  bits_result = ex_op.op1 | ex_op.op2;
            default:             bits_result = ex_op.op1 & ex_op.op2;
        endcase
    end

    assign shamt = ex_op.op2[SHW-1:0];
    assign shl   = ex_op.op1 << shamt;
    assign srl   = ex_op.op1 >> shamt;
    assign sra   = $signed(ex_op.op1) >>> shamt;

    always_comb
    begin
        if (!ex_op.ctrl.shift_right)
        begin
            shift_result = shl;
        end
        else if (ex_op.ctrl.shift_arith)
        begin
            shift_result = sra;
        end
        else
        begin
            shift_result = srl;
        end
    end

    always_comb
    begin
        case (1'b1)
            ex_op.csr_read:  alu_result = ex_op.csr_data;
            ex_op.res.cmp:   alu_result = {{MSB{1'b0}}, cmp_result};
            ex_op.res.bits:  alu_result = bits_result;
            ex_op.res.shift: alu_result = shift_result;
            default:         alu_result = sum[MSB:0];
        endcase
    end

    always_comb
    begin
        ex_res.result    = alu_result;
        ex_res.add       = sum[MSB:0];
        ex_res.pc_select = (ex_op.jal_jalr || (ex_op.branch && cmp_result)) &&
                           !ex_op.branch_pred;
        ex_res.pc_target = ex_op.pc_target_base + ex_op.pc_target_offset;
        ex_res.store     = ex_op.store;
        ex_res.reg_write = ex_op.reg_write;
        ex_res.rd        = ex_op.rd;
        ex_res.pc_next   = ex_op.pc_next;
        ex_res.res_src   = ex_op.res_src;
        ex_res.funct3    = ex_op.funct3;
        ex_res.to_trap   = ex_op.to_trap;
        case (ex_op.funct3[1:0])
            2'b00:
            begin
                ex_res.wdata = {LANES{ex_op.reg_data2[7:0]}};
                ex_res.wsel  = {{(LANES-1){1'b0}}, 1'b1} << sum[1:0];
            end
            2'b01:
            begin
                ex_res.wdata = {(LANES/2){ex_op.reg_data2[15:0]}};
                ex_res.wsel  = {{(LANES-2){1'b0}}, 2'b11} << {sum[1], 1'b0};
            end
            default:
            begin
                ex_res.wdata = ex_op.reg_data2;
                ex_res.wsel  = '1;
            end
        endcase
    end

    assign out_bus.valid   = ex_valid;
    assign out_bus.payload = ex_res;

    // Decode must never select two compare kinds at once
    a_cmp_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        (ex_valid && ex_op.res.cmp) |->
            $onehot0({ex_op.ctrl.cmp_eq, ex_op.ctrl.cmp_lts, ex_op.ctrl.cmp_ltu}));

endmodule

`default_nettype wire

// File: rtl/rv_result_port.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result_port
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_res_ack,
    rv_stage_if.dst                bus,
    output logic                   o_res_req,
    output rv_exec_pkg::exec_res_t o_res
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t                 state;
    logic                   full;
    logic                   drain;
    rv_exec_pkg::exec_res_t res_q;

    assign drain     = (state == ST_WAIT) && !i_res_ack;   // Host finished with the entry
    assign bus.ready = !full || drain;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state <= ST_IDLE;
            full  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE: state <= full ? ST_REQ : ST_IDLE;
                ST_REQ:  state <= i_res_ack ? ST_WAIT : ST_REQ;
                default: state <= i_res_ack ? ST_WAIT : ST_IDLE;
            endcase
            if (bus.valid && bus.ready)
            begin
                full <= 1'b1;
            end
            else if (drain)
            begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (bus.valid && bus.ready)
        begin
            res_q <= bus.payload;
        end
    end

    assign o_res_req = (state == ST_REQ);
    assign o_res     = res_q;

    a_res_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_res_req |=> $stable(o_res));

endmodule

`default_nettype wire

// File: rtl/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_top
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_flush,
    input  logic                   i_req,
    input  rv_exec_pkg::exec_op_t  i_op,
    input  logic                   i_res_ack,
    output logic                   o_ack,
    output logic                   o_res_req,
    output rv_exec_pkg::exec_res_t o_res
);

    rv_stage_if #(.payload_t(rv_exec_pkg::exec_op_t))  issue_bus ();
    rv_stage_if #(.payload_t(rv_exec_pkg::exec_res_t)) exec_bus ();

    rv_issue_port u_issue
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_req   (i_req),
        .i_op    (i_op),
        .o_ack   (o_ack),
        .bus     (issue_bus.src)
    );

    rv_alu_exec u_exec
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .in_bus  (issue_bus.dst),
        .out_bus (exec_bus.src)
    );

    // Result holder is outside the flush domain
    rv_result_port u_result
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_res_ack (i_res_ack),
        .bus       (exec_bus.dst),
        .o_res_req (o_res_req),
        .o_res     (o_res)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic o_clk,
    output logic o_reset
);

    initial
    begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;   // 8 ns period
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (4) @(posedge o_clk);
        #1;
        o_reset = 1'b0;   // Released off the edge like the other inputs
    end

endmodule

`default_nettype wire

// File: testbench/tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

    localparam int N_OPS        = 125;
    localparam int MAX_CYCLE    = N_OPS * 40 + 200;
    localparam int DRAIN_CYCLES = 100;

    logic                   clk;
    logic                   reset;
    logic                   i_flush;
    logic                   i_req;
    logic                   i_res_ack;
    logic                   o_ack;
    logic                   o_res_req;
    rv_exec_pkg::exec_op_t  i_op;
    rv_exec_pkg::exec_res_t o_res;
    rv_exec_pkg::exec_res_t exp_q[$];   // Expected results in issue order
    bit                     ack_block = 1'b0;
    int                     value_errors = 0;
    int                     other_errors = 0;

    tb_clock_gen u_clk_gen
    (
        .o_clk   (clk),
        .o_reset (reset)
    );

    rv_exec_top dut
    (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_flush   (i_flush),
        .i_req     (i_req),
        .i_op      (i_op),
        .i_res_ack (i_res_ack),
        .o_ack     (o_ack),
        .o_res_req (o_res_req),
        .o_res     (o_res)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Expected result of one operation, worked out from the ISA rules
    function automatic rv_exec_pkg::exec_res_t ref_result(input rv_exec_pkg::exec_op_t op);
        rv_exec_pkg::exec_res_t r;
        logic                   taken;
        logic [4:0]             n;
        logic [31:0]            sh;
        r = '0;
        n = op.op2[4:0];
        r.add = (op.ctrl.arith_sub || op.res.cmp) ? op.op1 - op.op2 : op.op1 + op.op2;
        if (op.ctrl.cmp_lts)
        begin
            taken = $signed(op.op1) < $signed(op.op2);
        end
        else if (op.ctrl.cmp_ltu)
        begin
            taken = op.op1 < op.op2;
        end
        else
        begin
            taken = op.op1 == op.op2;
        end
        taken = taken ^ op.ctrl.cmp_inv;
        if (!op.ctrl.shift_right)
        begin
            sh = op.op1 << n;
        end
        else
        begin
            sh = (op.op1 >> n) |
                 ({32{op.op1[31] & op.ctrl.shift_arith}} & ~(32'hffff_ffff >> n));
        end
        if (op.csr_read)
        begin
            r.result = op.csr_data;
        end
        else if (op.res.cmp)
        begin
            r.result[0] = taken;
        end
        else if (op.res.bits)
        begin
            r.result = op.ctrl.bits_xor ? op.op1 ^ op.op2 :
                       op.ctrl.bits_or  ? op.op1 | op.op2 : op.op1 & op.op2;
        end
        else
        begin
            r.result = op.res.shift ? sh : r.add;
        end
        r.pc_select = (op.jal_jalr || (op.branch && taken)) && !op.branch_pred;
        r.pc_target = op.pc_target_base + op.pc_target_offset;
        case (op.funct3[1:0])
            2'b00:
            begin
                r.wdata = {4{op.reg_data2[7:0]}};
                r.wsel  = 4'b0001 << r.add[1:0];
            end
            2'b01:
            begin
                r.wdata = {2{op.reg_data2[15:0]}};
                r.wsel  = r.add[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                r.wdata = op.reg_data2;
                r.wsel  = 4'b1111;
            end
        endcase
        r.store     = op.store;
        r.reg_write = op.reg_write;
        r.rd        = op.rd;
        r.pc_next   = op.pc_next;
        r.res_src   = op.res_src;
        r.funct3    = op.funct3;
        r.to_trap   = op.to_trap;
        return r;
    endfunction

    // Kinds 0-7 ALU, 8-10 compares, 11 branch, 12 jal/jalr, 13 store, 14 CSR read
    function automatic rv_exec_pkg::exec_op_t make_op(input int kind);
        rv_exec_pkg::exec_op_t op;
        int                    sel;
        op = '0;
        op.op1              = $urandom;
        op.op2              = $urandom;
        op.rd               = 5'($urandom);
        op.reg_write        = 1'($urandom);
        op.pc_next          = $urandom;
        op.pc_target_base   = $urandom;
        op.pc_target_offset = $urandom;
        op.res_src          = rv_exec_pkg::res_src_t'($urandom_range(2, 0));
        op.funct3           = 3'($urandom);
        op.reg_data2        = $urandom;
        op.csr_data         = $urandom;
        op.to_trap          = 1'($urandom);
        op.res.arith        = kind <= 1 || kind == 12 || kind == 13;
        op.ctrl.arith_sub   = kind == 1;
        op.res.bits         = kind >= 2 && kind <= 4;
        op.ctrl.bits_xor    = kind == 2;
        op.ctrl.bits_or     = kind == 3;
        op.ctrl.bits_and    = kind == 4;
        op.res.shift        = kind >= 5 && kind <= 7;
        op.ctrl.shift_right = kind == 6 || kind == 7;
        op.ctrl.shift_arith = kind == 7;
        op.res.cmp          = kind >= 8 && kind <= 11;
        op.branch           = kind == 11;
        op.jal_jalr         = kind == 12;
        op.branch_pred      = (kind == 11 || kind == 12) && $urandom_range(3, 0) == 0;
        op.store            = kind == 13;
        op.csr_read         = kind == 14;
        if (op.res.cmp)
        begin
            sel = (kind == 11) ? $urandom_range(2, 0) : kind - 8;
            op.ctrl.cmp_eq  = sel == 0;
            op.ctrl.cmp_lts = sel == 1;
            op.ctrl.cmp_ltu = sel == 2;
            op.ctrl.cmp_inv = 1'($urandom);
            if ($urandom_range(2, 0) == 0)
            begin
                op.op2 = op.op1;   // Equal operands are rare otherwise
            end
        end
        if (op.res.shift && $urandom_range(1, 0) == 0)
        begin
            op.op2[4:0] = $urandom_range(1, 0) == 0 ? 5'd0 : 5'd31;
        end
        if (op.csr_read)
        begin
            op.res = rv_exec_pkg::alu_res_t'(4'b0001 << $urandom_range(3, 0));
        end
        return op;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else
        begin
            value_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    // Four-phase issue; a flushed operation is not expected back
    task automatic issue_op(input rv_exec_pkg::exec_op_t op, input bit keep);
        next_cycle();
        i_op  = op;
        i_req = 1'b1;
        while (!o_ack)
        begin
            next_cycle();
        end
        if (keep)
        begin
            exp_q.push_back(ref_result(op));
        end
        i_req = 1'b0;
        while (o_ack)
        begin
            next_cycle();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || o_res_req || i_res_ack) && waited < DRAIN_CYCLES)
        begin
            next_cycle();
            waited++;
        end
        next_cycle();
    endtask

    initial
    begin : ack_responder
        i_res_ack = 1'b0;
        forever
        begin
            next_cycle();
            if (o_res_req && !ack_block)
            begin
                repeat ($urandom_range(4, 0)) next_cycle();
                i_res_ack = 1'b1;
                while (o_res_req)
                begin
                    next_cycle();
                end
                repeat ($urandom_range(3, 0)) next_cycle();
                i_res_ack = 1'b0;
            end
        end
    end

    initial
    begin : compare_results
        rv_exec_pkg::exec_res_t want;
        logic                   seen_req;
        seen_req = 1'b0;
        forever
        begin
            next_cycle();
            if (o_res_req && !seen_req)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    other_errors++;
                    $display("Result delivered with no operation outstanding at %0t", $time);
                end
                if (exp_q.size() != 0)
                begin
                    want = exp_q.pop_front();
                    check_field("result", o_res.result, want.result);
                    check_field("add", o_res.add, want.add);
                    check_field("pc_select", 32'(o_res.pc_select), 32'(want.pc_select));
                    check_field("pc_target", o_res.pc_target, want.pc_target);
                    check_field("store", 32'(o_res.store), 32'(want.store));
                    check_field("wdata", o_res.wdata, want.wdata);
                    check_field("wsel", 32'(o_res.wsel), 32'(want.wsel));
                    check_field("reg_write", 32'(o_res.reg_write), 32'(want.reg_write));
                    check_field("rd", 32'(o_res.rd), 32'(want.rd));
                    check_field("pc_next", o_res.pc_next, want.pc_next);
                    check_field("res_src", 32'(o_res.res_src), 32'(want.res_src));
                    check_field("funct3", 32'(o_res.funct3), 32'(want.funct3));
                    check_field("to_trap", 32'(o_res.to_trap), 32'(want.to_trap));
                end
            end
            seen_req = o_res_req;
        end
    end

    initial
    begin : watchdog
        repeat (MAX_CYCLE) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results outstanding",
                 MAX_CYCLE, exp_q.size());
        $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("Test failed");
        $finish;
    end

    initial
    begin : stimulus
        rv_exec_pkg::exec_op_t op;
        int                    i;
        int                    w;
        int                    a;
        void'($urandom(64));
        i_req   = 1'b0;
        i_flush = 1'b0;
        i_op    = '0;
        @(negedge reset);
        next_cycle();
        check_field("o_ack", 32'(o_ack), 32'h0);
        check_field("o_res_req", 32'(o_res_req), 32'h0);
        repeat (10) next_cycle();   // Nothing may come out before the first request
        for (i = 0; i < 60; i++)
        begin
            issue_op(make_op($urandom_range(7, 0)), 1'b1);
        end
        for (i = 0; i < 40; i++)
        begin
            issue_op(make_op($urandom_range(12, 8)), 1'b1);
        end
        for (w = 0; w < 3; w++)
        begin
            for (a = 0; a < 4; a++)
            begin
                op = make_op(13);
                op.funct3[1:0] = 2'(w);
                op.op1[1:0]    = 2'(a);
                op.op2[1:0]    = 2'b00;
                issue_op(op, 1'b1);
            end
        end
        for (i = 0; i < 6; i++)
        begin
            issue_op(make_op(14), 1'b1);
        end
        drain();
        ack_block = 1'b1;   // Three operations fill all three holders
        for (i = 0; i < 3; i++)
        begin
            issue_op(make_op($urandom_range(7, 0)), 1'b1);
        end
        repeat ($urandom_range(60, 30)) next_cycle();
        ack_block = 1'b0;
        drain();
        ack_block = 1'b1;
        issue_op(make_op($urandom_range(7, 0)), 1'b1);
        issue_op(make_op($urandom_range(7, 0)), 1'b0);
        issue_op(make_op($urandom_range(7, 0)), 1'b0);
        i_flush = 1'b1;
        next_cycle();
        i_flush = 1'b0;
        repeat (5) next_cycle();
        ack_block = 1'b0;
        issue_op(make_op($urandom_range(14, 0)), 1'b1);
        drain();
        repeat (10) next_cycle();
        assert (exp_q.size() == 0)
        else
        begin
            other_errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/rv_exec_pkg.sv
rtl/rv_stage_if.sv
rtl/rv_issue_port.sv
rtl/rv_alu_exec.sv
rtl/rv_result_port.sv
rtl/rv_exec_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_exec.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_rv_exec \
    -o tb_rv_exec > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_rv_exec > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
